// ==== verilog.f ====
stlb_pkg.sv
stlb_regs.sv
stlb_ways.sv
stlb_lookup.sv
stlb_top.sv
tb_stlb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the translation buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_stlb -o sim_stlb \
	> "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_stlb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$SIM_LOG"; then
	exit 1
fi
exit 0

// ==== tb_stlb.sv ====
`timescale 1ns/10ps
`default_nettype none
// ======================================================================
// Testbench for the set-associative translation buffer
// Shadow table model, pipelined lookups and register port checks
// ======================================================================

module tb_stlb;
	import stlb_pkg::*;

	localparam int ASSOC       = 4;
	localparam int CLK_PERIOD  = 10;
	localparam int TEST_BUDGET = 200;
	localparam int RUN_CYCLES  = 10 + 5 * TEST_BUDGET + 200;

	logic        clk_g = 1'b0;
	logic        rst_i;
	logic        reg_cs_i;
	logic        reg_we_i;
	logic [2:0]  reg_addr_i;
	logic [31:0] reg_wdata_i;
	logic [31:0] reg_rdata_o;
	logic        reg_ack_o;
	xlat_req_t   xlat_req_i;
	xlat_resp_t  xlat_resp_o;
	logic        miss_irq_o;

	integer seed = 20395;
	int     cycle = 0;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	int     test_err0;
	string  test_name;

	// Shadow of the way RAMs and valid bits
	tlb_entry_t sh_ent [ASSOC][ENTRIES];
	logic       sh_val [ASSOC][ENTRIES];

	// Lookups in flight, oldest first
	xlat_resp_t exp_q[$];
	xlat_req_t  sent_q[$];
	int         stamp_q[$];

	stlb_top #(.ASSOC(ASSOC)) uut (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.reg_cs_i    (reg_cs_i),
		.reg_we_i    (reg_we_i),
		.reg_addr_i  (reg_addr_i),
		.reg_wdata_i (reg_wdata_i),
		.reg_rdata_o (reg_rdata_o),
		.reg_ack_o   (reg_ack_o),
		.xlat_req_i  (xlat_req_i),
		.xlat_resp_o (xlat_resp_o),
		.miss_irq_o  (miss_irq_o)
	);

	always #(CLK_PERIOD / 2) clk_g = ~clk_g;

	always @(posedge clk_g) cycle <= cycle + 1;

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// First matching way wins, r is rwx[2] and w is rwx[1]
	function automatic xlat_resp_t ref_translate(xlat_req_t req);
		xlat_resp_t r;
		logic [3:0] idx;
		logic       found;
		r       = '0;
		r.valid = req.valid;
		idx     = req.vadr[15:12];
		found   = 1'b0;
		for (int w = 0; w < ASSOC; w++) begin
			if (!found && sh_val[w][idx] && sh_ent[w][idx].pte.v
				&& sh_ent[w][idx].vpn.tag == req.vadr[31:16]
				&& (sh_ent[w][idx].pte.g || sh_ent[w][idx].vpn.asid == req.asid)) begin
				found   = 1'b1;
				r.hit   = 1'b1;
				r.rwx   = sh_ent[w][idx].pte.rwx;
				r.padr  = {sh_ent[w][idx].pte.ppn, req.vadr[11:0]};
				r.fault = req.we ? !sh_ent[w][idx].pte.rwx[1] : !sh_ent[w][idx].pte.rwx[2];
			end
		end
		return r;
	endfunction

	// Random mode way is unknown, so reuse a slot with the same tag or a free one
	task automatic model_write(input int way, input logic [3:0] idx, input tlb_entry_t e,
		input logic rnd);
		int slot;
		slot = rnd ? -1 : way;
		for (int w = 0; w < ASSOC; w++)
			if (slot < 0 && sh_val[w][idx] && sh_ent[w][idx].vpn.tag == e.vpn.tag)
				slot = w;
		for (int w = 0; w < ASSOC; w++)
			if (slot < 0 && !sh_val[w][idx])
				slot = w;
		if (slot < 0)
			slot = 0;
		sh_ent[slot][idx] = e;
		sh_val[slot][idx] = e.pte.v;
	endtask

	task automatic model_clear();
		for (int w = 0; w < ASSOC; w++)
			for (int i = 0; i < ENTRIES; i++)
				sh_val[w][i] = 1'b0;
	endtask

	// ======================================================================
	// Drivers and checks
	// ======================================================================

	task automatic step();
		@(posedge clk_g);
		#1;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_ack();
		checks++;
		assert (reg_ack_o === 1'b1) else begin
			$display("ERROR at %0t: register port gave no ack one cycle after the strobe",
				$time);
			errors++;
		end
	endtask

	task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
		step();
		reg_cs_i    = 1'b1;
		reg_we_i    = 1'b1;
		reg_addr_i  = addr;
		reg_wdata_i = data;
		step();
		reg_cs_i    = 1'b0;
		reg_we_i    = 1'b0;
		reg_wdata_i = '0;
		check_ack();
	endtask

	task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
		step();
		reg_cs_i   = 1'b1;
		reg_we_i   = 1'b0;
		reg_addr_i = addr;
		step();
		reg_cs_i = 1'b0;
		check_ack();
		data = reg_rdata_o;
	endtask

	task automatic check_reg(input logic [2:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] d;
		reg_read(addr, d);
		check_value(d, exp, what);
	endtask

	task automatic write_entry(input int way, input logic [3:0] idx, input vpn_t vpn,
		input pte_t pte, input logic rnd);
		logic [31:0] ctrl;
		ctrl      = '0;
		ctrl[3:0] = idx;
		ctrl[6:4] = way[2:0];
		ctrl[8]   = rnd;
		reg_write(REG_PTE, 32'(pte));
		reg_write(REG_VPN, 32'(vpn));
		reg_write(REG_CTRL, ctrl);
		reg_write(REG_CMD, 32'd1);
		model_write(way, idx, {vpn, pte}, rnd);
	endtask

	task automatic lookup(input logic [31:0] vadr, input logic [7:0] asid, input logic we);
		xlat_req_t r;
		r.valid = 1'b1;
		r.we    = we;
		r.asid  = asid;
		r.vadr  = vadr;
		step();
		xlat_req_i = r;
		exp_q.push_back(ref_translate(r));
		sent_q.push_back(r);
		stamp_q.push_back(cycle);
	endtask

	task automatic drain_lookups();
		int n;
		step();
		xlat_req_i = '0;
		n = 0;
		while (exp_q.size() != 0 && n < 8) begin
			@(posedge clk_g);
			n++;
		end
		checks++;
		assert (exp_q.size() == 0) else begin
			$display("ERROR at %0t: %0d lookup responses never arrived", $time, exp_q.size());
			errors++;
			exp_q.delete();
			sent_q.delete();
			stamp_q.delete();
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("Test %0d %s: done, %0d errors", tests, test_name, errors - test_err0);
	endtask

	// Response compare, sampled away from the clock edge
	always @(negedge clk_g) begin : compare_resp
		xlat_resp_t exp_r;
		xlat_req_t  req_r;
		int         stamp;
		if (!rst_i && xlat_resp_o.valid) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("ERROR at %0t: response arrived with no request in flight", $time);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_r = exp_q.pop_front();
				req_r = sent_q.pop_front();
				stamp = stamp_q.pop_front();
				assert (xlat_resp_o === exp_r) else begin
					$display("MISMATCH at %0t: vadr %h asid %h we %b gave %h, expected %h",
						$time, req_r.vadr, req_r.asid, req_r.we, xlat_resp_o, exp_r);
					errors++;
				end
				assert (cycle == stamp + 2) else begin
					$display("ERROR at %0t: response came %0d cycles after its request",
						$time, cycle - stamp);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		#(RUN_CYCLES * CLK_PERIOD);
		$display("ERROR: run timed out after %0d cycles", RUN_CYCLES);
		$display("Checks failed");
		$finish;
	end

	// ======================================================================
	// Tests
	// ======================================================================

	initial begin : main
		logic [15:0] pg_tag [6];
		logic [3:0]  pg_idx [6];
		logic [7:0]  pg_asid [6];
		vpn_t        vpn;
		pte_t        pte;
		logic [31:0] r;
		logic [2:0]  k;
		logic [31:0] miss_vadr;
		int          n;

		rst_i       = 1'b1;
		reg_cs_i    = 1'b0;
		reg_we_i    = 1'b0;
		reg_addr_i  = '0;
		reg_wdata_i = '0;
		xlat_req_i  = '0;
		model_clear();
		repeat (10) @(posedge clk_g);
		#1;
		rst_i = 1'b0;

		begin_test("reset state");
		check_value(32'(miss_irq_o), 32'd0, "miss_irq_o after reset");
		check_reg(REG_PTE, 32'd0, "PTE after reset");
		check_reg(REG_VPN, 32'd0, "VPN after reset");
		check_reg(REG_MISS_ADR, 32'd0, "miss address after reset");
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			lookup(rand32(), r[7:0], r[8]);
		end
		drain_lookups();
		end_test();

		begin_test("explicit writes and pipelined lookups");
		for (int i = 0; i < 6; i++) begin
			r          = rand32();
			pg_tag[i]  = r[15:0];
			pg_idx[i]  = r[19:16];
			pg_asid[i] = r[27:20];
			r          = rand32();
			pte.v      = (i != 5);
			pte.g      = 1'b0;
			pte.rwx    = r[22:20];
			pte.ppn    = r[19:0];
			vpn.asid   = pg_asid[i];
			vpn.tag    = pg_tag[i];
			write_entry(i % ASSOC, pg_idx[i], vpn, pte, 1'b0);
		end
		for (int i = 0; i < 32; i++) begin
			r = rand32();
			k = r[2:0];
			if (k < 3'd6)
				lookup({pg_tag[k], pg_idx[k], r[31:20]}, pg_asid[k], r[3]);
			else
				lookup(rand32(), r[15:8], r[3]);
		end
		drain_lookups();
		end_test();

		begin_test("ASID, global and permission faults");
		write_entry(0, 4'h3, '{asid: 8'h11, tag: 16'h1234}, '{1'b1, 1'b0, 3'b100, 20'h0a0a0}, 1'b0);
		write_entry(1, 4'h5, '{asid: 8'h22, tag: 16'h5678}, '{1'b1, 1'b1, 3'b010, 20'h0b0b0}, 1'b0);
		lookup(32'h1234_3abc, 8'h11, 1'b0);
		lookup(32'h1234_3abc, 8'h11, 1'b1);
		lookup(32'h1234_3abc, 8'h33, 1'b0);
		lookup(32'h5678_5123, 8'h99, 1'b0);
		lookup(32'h5678_5123, 8'h22, 1'b1);
		drain_lookups();
		end_test();

		begin_test("miss capture and interrupt");
		reg_write(REG_MISS_ADR, 32'd0);
		check_value(32'(miss_irq_o), 32'd0, "miss_irq_o after clear");
		miss_vadr = 32'hbeef_75a4;
		lookup(32'hdead_7001, 8'h44, 1'b0);
		lookup(miss_vadr, 8'h5a, 1'b1);
		lookup(32'h1234_3004, 8'h11, 1'b0);
		drain_lookups();
		n = 0;
		while (!miss_irq_o && n < 8) begin
			step();
			n++;
		end
		check_value(32'(miss_irq_o), 32'd1, "miss_irq_o after a miss");
		check_reg(REG_MISS_ADR, miss_vadr, "miss address");
		check_reg(REG_MISS_ASID, 32'h5a, "miss ASID");
		reg_write(REG_MISS_ADR, 32'hffff_ffff);
		check_value(32'(miss_irq_o), 32'd0, "miss_irq_o after software clear");
		check_reg(REG_MISS_ADR, miss_vadr, "miss address after clear");
		end_test();

		begin_test("read-back, invalidate and random mode");
		vpn = '{asid: 8'h77, tag: 16'hcafe};
		pte = '{1'b1, 1'b0, 3'b101, 20'habcde};
		write_entry(2, 4'h9, vpn, pte, 1'b0);
		reg_write(REG_PTE, 32'd0);
		reg_write(REG_VPN, 32'd0);
		reg_write(REG_CMD, 32'd2);
		check_reg(REG_PTE, 32'(pte), "PTE read-back");
		check_reg(REG_VPN, 32'(vpn), "VPN read-back");
		reg_write(REG_CMD, 32'd4);
		model_clear();
		for (int i = 0; i < 6; i++)
			lookup({pg_tag[i], pg_idx[i], 12'h010}, pg_asid[i], 1'b0);
		lookup(32'h1234_3abc, 8'h11, 1'b0);
		lookup(32'h5678_5123, 8'h22, 1'b1);
		lookup(32'hcafe_9321, 8'h77, 1'b0);
		drain_lookups();
		write_entry(0, 4'h9, vpn, pte, 1'b1);
		lookup(32'hcafe_9321, 8'h77, 1'b0);
		lookup(32'hcafe_9fff, 8'h77, 1'b1);
		lookup(32'hcafe_9321, 8'h78, 1'b0);
		drain_lookups();
		end_test();

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== stlb_top.sv ====
`timescale 1ns/10ps
`default_nettype none
// ====================================================================
// Set-associative translation buffer, top level
// ====================================================================

module stlb_top #(
	parameter int ASSOC = 4
) (
	input  wire                       clk_g,
	input  wire                       rst_i,
	input  wire                       reg_cs_i,
	input  wire                       reg_we_i,
	input  wire  [2:0]                reg_addr_i,
	input  wire  [31:0]               reg_wdata_i,
	output wire  [31:0]               reg_rdata_o,
	output wire                       reg_ack_o,
	input  wire  stlb_pkg::xlat_req_t xlat_req_i,
	output wire  stlb_pkg::xlat_resp_t xlat_resp_o,
	output wire                       miss_irq_o
);
	import stlb_pkg::*;

	wire                          tbl_wr;
	wire                          tbl_rd;
	wire [$clog2(ASSOC)-1:0]      tbl_way;
	wire [LOG_ENTRIES-1:0]        tbl_index;
	wire tlb_entry_t              tbl_entry;
	wire                          inv_all;
	wire tlb_entry_t              rd_entry;
	wire tlb_entry_t [ASSOC-1:0]  lk_entries;
	wire [ASSOC-1:0]              lk_valid;
	wire miss_t                   miss;

	stlb_regs #(.ASSOC(ASSOC)) u_regs (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.reg_cs_i    (reg_cs_i),
		.reg_we_i    (reg_we_i),
		.reg_addr_i  (reg_addr_i),
		.reg_wdata_i (reg_wdata_i),
		.rd_entry_i  (rd_entry),
		.miss_i      (miss),
		.reg_rdata_o (reg_rdata_o),
		.reg_ack_o   (reg_ack_o),
		.tbl_wr_o    (tbl_wr),
		.tbl_rd_o    (tbl_rd),
		.tbl_way_o   (tbl_way),
		.tbl_index_o (tbl_index),
		.tbl_entry_o (tbl_entry),
		.inv_all_o   (inv_all),
		.miss_irq_o  (miss_irq_o)
	);

	// Lookup index is the low page-number bits
	stlb_ways #(.ASSOC(ASSOC)) u_ways (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.wr_i         (tbl_wr),
		.rd_i         (tbl_rd),
		.way_i        (tbl_way),
		.index_i      (tbl_index),
		.entry_i      (tbl_entry),
		.inv_all_i    (inv_all),
		.lk_index_i   (xlat_req_i.vadr[PAGE_BITS +: LOG_ENTRIES]),
		.rd_entry_o   (rd_entry),
		.lk_entries_o (lk_entries),
		.lk_valid_o   (lk_valid)
	);

	stlb_lookup #(.ASSOC(ASSOC)) u_lookup (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.req_i        (xlat_req_i),
		.lk_entries_i (lk_entries),
		.lk_valid_i   (lk_valid),
		.resp_o       (xlat_resp_o),
		.miss_o       (miss)
	);

endmodule

`default_nettype wire

// ==== stlb_lookup.sv ====
`timescale 1ns/10ps
`default_nettype none
// ====================================================================
// Translation buffer lookup stage
// Tag and ASID compare over all ways, registered translation result
// ====================================================================

module stlb_lookup #(
	parameter int ASSOC = 4
) (
	input  wire                                    clk_g,
	input  wire                                    rst_i,
	input  wire  stlb_pkg::xlat_req_t              req_i,
	input  wire  stlb_pkg::tlb_entry_t [ASSOC-1:0] lk_entries_i,
	input  wire  [ASSOC-1:0]                       lk_valid_i,
	output stlb_pkg::xlat_resp_t                   resp_o,
	output stlb_pkg::miss_t                        miss_o
);
	import stlb_pkg::*;

	xlat_req_t  req_q;
	logic [ASSOC-1:0] way_hit;
	logic       hit;
	tlb_entry_t hit_entry;
	xlat_resp_t resp_d;
	miss_t      miss_d;

	// Line the request up with the RAM outputs
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			req_q <= '0;
		else
			req_q <= req_i;
	end

	// ================================================================
	// Compare
	// ================================================================

	genvar w;
	generate
		for (w = 0; w < ASSOC; w++) begin : g_cmp
			assign way_hit[w] = lk_valid_i[w] & lk_entries_i[w].pte.v
				& (lk_entries_i[w].vpn.tag == req_q.vadr[ADDR_W-1 -: TAG_W])
				& (lk_entries_i[w].pte.g | (lk_entries_i[w].vpn.asid == req_q.asid));
		end
	endgenerate

	assign hit = req_q.valid & (|way_hit);

	// Lowest numbered way wins, so scan downwards
	always_comb begin
		hit_entry = '0;
		for (int i = ASSOC - 1; i >= 0; i--) begin
			if (way_hit[i])
				hit_entry = lk_entries_i[i];
		end
	end

	always_comb begin
		resp_d       = '0;
		resp_d.valid = req_q.valid;
		resp_d.hit   = hit;
		if (hit) begin
			resp_d.rwx  = hit_entry.pte.rwx;
			resp_d.padr = {hit_entry.pte.ppn, req_q.vadr[PAGE_BITS-1:0]};
			// rwx[1] is w, rwx[2] is r
			resp_d.fault = req_q.we ? ~hit_entry.pte.rwx[1] : ~hit_entry.pte.rwx[2];
		end
	end

	always_comb begin
		miss_d.valid = req_q.valid & ~hit;
		miss_d.asid  = req_q.asid;
		miss_d.vadr  = req_q.vadr;
	end

	// ================================================================
	// Result registers
	// ================================================================

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			resp_o <= '0;
			miss_o <= '0;
		end else begin
			resp_o <= resp_d;
			miss_o <= miss_d;
		end
	end

endmodule

`default_nettype wire

// ==== stlb_ways.sv ====
`timescale 1ns/10ps
`default_nettype none
// ====================================================================
// Translation buffer way storage
// One RAM per way with software and lookup ports, plus valid bits
// ====================================================================

module stlb_ways #(
	parameter int ASSOC = 4
) (
	input  wire                                  clk_g,
	input  wire                                  rst_i,
	input  wire                                  wr_i,
	input  wire                                  rd_i,
	input  wire  [$clog2(ASSOC)-1:0]             way_i,
	input  wire  [stlb_pkg::LOG_ENTRIES-1:0]     index_i,
	input  wire  stlb_pkg::tlb_entry_t           entry_i,
	input  wire                                  inv_all_i,
	input  wire  [stlb_pkg::LOG_ENTRIES-1:0]     lk_index_i,
	output wire  stlb_pkg::tlb_entry_t           rd_entry_o,
	output wire  stlb_pkg::tlb_entry_t [ASSOC-1:0] lk_entries_o,
	output logic [ASSOC-1:0]                     lk_valid_o
);
	import stlb_pkg::*;

	localparam int WAY_W = $clog2(ASSOC);

	wire tlb_entry_t [ASSOC-1:0]   rd_all;
	logic [WAY_W-1:0]              rd_way_q;
	logic [ENTRIES-1:0][ASSOC-1:0] valid_q;

	// ================================================================
	// Way RAMs
	// ================================================================

	genvar w;
	generate
		for (w = 0; w < ASSOC; w++) begin : g_way
			tlb_entry_t mem [ENTRIES];
			tlb_entry_t rd_q;
			tlb_entry_t lk_q;

			// Port A write and read, port B lookup read
			always_ff @(posedge clk_g) begin
				if (wr_i && way_i == WAY_W'(w))
					mem[index_i] <= entry_i;
				if (rd_i)
					rd_q <= mem[index_i];
				lk_q <= mem[lk_index_i];
			end

			assign rd_all[w]       = rd_q;
			assign lk_entries_o[w] = lk_q;
		end
	endgenerate

	always_ff @(posedge clk_g) begin
		if (rd_i)
			rd_way_q <= way_i;
	end

	assign rd_entry_o = rd_all[rd_way_q];

	// ================================================================
	// Valid bits
	// ================================================================

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			valid_q    <= '0;
			lk_valid_o <= '0;
		end else begin
			lk_valid_o <= valid_q[lk_index_i];
			if (inv_all_i)
				valid_q <= '0;
			else if (wr_i)
				valid_q[index_i][way_i] <= entry_i.pte.v;
		end
	end

endmodule

`default_nettype wire

// ==== stlb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
// ====================================================================
// Translation buffer register block
// Staging registers, table commands, way counter and miss capture
// ====================================================================

module stlb_regs #(
	parameter int ASSOC = 4
) (
	input  wire                                clk_g,
	input  wire                                rst_i,
	input  wire                                reg_cs_i,
	input  wire                                reg_we_i,
	input  wire  [2:0]                         reg_addr_i,
	input  wire  [31:0]                        reg_wdata_i,
	input  wire  stlb_pkg::tlb_entry_t         rd_entry_i,
	input  wire  stlb_pkg::miss_t              miss_i,
	output logic [31:0]                        reg_rdata_o,
	output logic                               reg_ack_o,
	output logic                               tbl_wr_o,
	output logic                               tbl_rd_o,
	output logic [$clog2(ASSOC)-1:0]           tbl_way_o,
	output logic [stlb_pkg::LOG_ENTRIES-1:0]   tbl_index_o,
	output stlb_pkg::tlb_entry_t               tbl_entry_o,
	output logic                               inv_all_o,
	output logic                               miss_irq_o
);
	import stlb_pkg::*;

	localparam int WAY_W         = $clog2(ASSOC);
	localparam int CTRL_WAY_LSB  = 4;
	localparam int CTRL_RAND_BIT = 8;

	pte_t                   pte_q;
	vpn_t                   vpn_q;
	logic [LOG_ENTRIES-1:0] ctrl_index_q;
	logic [2:0]             ctrl_way_q;
	logic                   ctrl_rand_q;
	logic [ADDR_W-1:0]      miss_adr_q;
	logic [ASID_W-1:0]      miss_asid_q;
	logic [WAY_W-1:0]       rand_way_q;
	logic                   rd_load_q;
	logic                   reg_wr;
	logic                   reg_rd;
	logic                   cmd_wr;
	logic [31:0]            ctrl_word;
	logic [31:0]            rdata_mux;

	assign reg_wr = reg_cs_i & reg_we_i;
	assign reg_rd = reg_cs_i & ~reg_we_i;
	assign cmd_wr = reg_wr & (reg_addr_i == REG_CMD);

	// ================================================================
	// Table commands
	// ================================================================

	assign tbl_wr_o    = cmd_wr & reg_wdata_i[0];
	assign tbl_rd_o    = cmd_wr & reg_wdata_i[1];
	assign inv_all_o   = cmd_wr & reg_wdata_i[2];
	assign tbl_index_o = ctrl_index_q;
	// Random mode only steers writes, reads always use the way field
	assign tbl_way_o   = (tbl_wr_o & ctrl_rand_q) ? rand_way_q : ctrl_way_q[WAY_W-1:0];

	always_comb begin
		tbl_entry_o.vpn = vpn_q;
		tbl_entry_o.pte = pte_q;
	end

	// Rotating way, holds still on the cycle a write goes out
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			rand_way_q <= '0;
		else if (!tbl_wr_o) begin
			if (rand_way_q == WAY_W'(ASSOC - 1))
				rand_way_q <= '0;
			else
				rand_way_q <= rand_way_q + 1'b1;
		end
	end

	// ================================================================
	// Register file
	// ================================================================

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			pte_q        <= '0;
			vpn_q        <= '0;
			ctrl_index_q <= '0;
			ctrl_way_q   <= '0;
			ctrl_rand_q  <= 1'b0;
			rd_load_q    <= 1'b0;
		end else begin
			rd_load_q <= tbl_rd_o;
			if (reg_wr) begin
				case (reg_addr_i)
					REG_PTE: pte_q <= pte_t'(reg_wdata_i[$bits(pte_t)-1:0]);
					REG_VPN: vpn_q <= vpn_t'(reg_wdata_i[$bits(vpn_t)-1:0]);
					REG_CTRL: begin
						ctrl_index_q <= reg_wdata_i[LOG_ENTRIES-1:0];
						ctrl_way_q   <= reg_wdata_i[CTRL_WAY_LSB +: 3];
						ctrl_rand_q  <= reg_wdata_i[CTRL_RAND_BIT];
					end
					default: ;
				endcase
			end
			// Read-back lands one cycle after the RAM strobe
			if (rd_load_q) begin
				pte_q <= rd_entry_i.pte;
				vpn_q <= rd_entry_i.vpn;
			end
		end
	end

	// Miss capture, a new miss beats a clear in the same cycle
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			miss_adr_q  <= '0;
			miss_asid_q <= '0;
			miss_irq_o  <= 1'b0;
		end else begin
			if (reg_wr && reg_addr_i == REG_MISS_ADR)
				miss_irq_o <= 1'b0;
			if (miss_i.valid) begin
				miss_adr_q  <= miss_i.vadr;
				miss_asid_q <= miss_i.asid;
				miss_irq_o  <= 1'b1;
			end
		end
	end

	always_comb begin
		ctrl_word = '0;
		ctrl_word[LOG_ENTRIES-1:0]     = ctrl_index_q;
		ctrl_word[CTRL_WAY_LSB +: 3]   = ctrl_way_q;
		ctrl_word[CTRL_RAND_BIT]       = ctrl_rand_q;
	end

	always_comb begin
		case (reg_addr_i)
			REG_PTE:       rdata_mux = 32'(pte_q);
			REG_VPN:       rdata_mux = 32'(vpn_q);
			REG_MISS_ADR:  rdata_mux = miss_adr_q;
			REG_MISS_ASID: rdata_mux = 32'(miss_asid_q);
			REG_CTRL:      rdata_mux = ctrl_word;
			default:       rdata_mux = '0;
		endcase
	end

	// Ack and read data one cycle after the strobe
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			reg_ack_o   <= 1'b0;
			reg_rdata_o <= '0;
		end else begin
			reg_ack_o   <= reg_cs_i;
			reg_rdata_o <= reg_rd ? rdata_mux : '0;
		end
	end

endmodule

`default_nettype wire

// ==== stlb_pkg.sv ====
`default_nettype none
// ====================================================================
// Shared translation buffer definitions
// Widths, table entry, translate port structs and register offsets
// ====================================================================

package stlb_pkg;

	// Address split  [31:16] tag, [15:12] index, [11:0] page offset
	localparam int ADDR_W      = 32;
	localparam int PAGE_BITS   = 12;
	localparam int LOG_ENTRIES = 4;
	localparam int ENTRIES     = 1 << LOG_ENTRIES;
	localparam int TAG_W       = ADDR_W - PAGE_BITS - LOG_ENTRIES;
	localparam int PPN_W       = 20;
	localparam int ASID_W      = 8;

	// Page table entry, as held in the PTE register
	typedef struct packed {
		logic             v;
		logic             g;
		logic [2:0]       rwx;
		logic [PPN_W-1:0] ppn;
	} pte_t;

	typedef struct packed {
		logic [ASID_W-1:0] asid;
		logic [TAG_W-1:0]  tag;
	} vpn_t;

	// One way RAM word
	typedef struct packed {
		vpn_t vpn;
		pte_t pte;
	} tlb_entry_t;

	typedef struct packed {
		logic              valid;
		logic              we;
		logic [ASID_W-1:0] asid;
		logic [ADDR_W-1:0] vadr;
	} xlat_req_t;

	typedef struct packed {
		logic              valid;
		logic              hit;
		logic              fault;
		logic [2:0]        rwx;
		logic [ADDR_W-1:0] padr;
	} xlat_resp_t;

	typedef struct packed {
		logic              valid;
		logic [ASID_W-1:0] asid;
		logic [ADDR_W-1:0] vadr;
	} miss_t;

	// Register map
	localparam logic [2:0] REG_PTE       = 3'd0;
	localparam logic [2:0] REG_VPN       = 3'd1;
	localparam logic [2:0] REG_MISS_ADR  = 3'd2;
	localparam logic [2:0] REG_MISS_ASID = 3'd3;
	localparam logic [2:0] REG_CTRL      = 3'd6;
	localparam logic [2:0] REG_CMD       = 3'd7;

endpackage

`default_nettype wire
